//--- hdl/host_pkg.sv
// Host domain shared definitions
// Bus widths, L2 geometry, address map and control register layout
package host_pkg;

  // Host bus
  localparam int unsigned ADDR_WIDTH      = 32;
  localparam int unsigned DATA_WIDTH      = 64;

  // L2 geometry defaults, a bank word is half a host word
  localparam int unsigned BANK_DATA_WIDTH = 32;
  localparam int unsigned NB_L2_BANKS     = 4;
  localparam int unsigned L2_BANK_WORDS   = 256;

  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;

  // Address map
  localparam addr_t L2_BASE   = 32'h1C00_0000;
  localparam addr_t CTRL_BASE = 32'h1A10_0000;
  localparam addr_t CTRL_SIZE = 32'd32;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_CTRL,
    TGT_ERR
  } target_e;

  // Control register offsets
  localparam logic [4:0] REG_CTRL    = 5'h00;
  localparam logic [4:0] REG_DMA_CNT = 5'h08;
  localparam logic [4:0] REG_EOC_CNT = 5'h10;
  localparam logic [4:0] REG_SCRATCH = 5'h18;

  // Fields of REG_CTRL
  localparam int unsigned CTRL_FETCH_EN_BIT = 0;
  localparam int unsigned CTRL_SA_BOOT_BIT  = 1;
  localparam int unsigned CTRL_H2C_IRQ_BIT  = 2;

endpackage

//--- hdl/reset_sync.sv
// SoC and cluster reset sequencing
// The SoC leaves reset two cycles after reset_i falls and the cluster
// follows one cycle after the SoC
module reset_sync (
  input  logic clk_i,
  input  logic reset_i,
  output logic soc_rst_o,
  output logic cluster_rst_o
);

  logic [1:0] soc_rst_q;
  logic       cluster_rst_q;

  // Release shift register, ones drain out after reset_i falls
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      soc_rst_q <= 2'b11;
    end else begin
      soc_rst_q <= {soc_rst_q[0], 1'b0};
    end
  end

  // One extra stage for the cluster
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cluster_rst_q <= 1'b1;
    end else begin
      cluster_rst_q <= soc_rst_q[1];
    end
  end

  assign soc_rst_o     = soc_rst_q[1];
  assign cluster_rst_o = cluster_rst_q;

endmodule

//--- hdl/edge_propagator_rx.sv
// Receive side of a toggle based event crossing
// Turns each toggle of valid_i into a one-cycle pulse on valid_o and
// returns the synchronized level as acknowledge
module edge_propagator_rx (
  input  logic clk_i,
  input  logic reset_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic sync1_q;
  logic sync2_q;
  logic prev_q;
  logic pulse_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      prev_q  <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      // Two-flop synchronizer
      sync1_q <= valid_i;
      sync2_q <= sync1_q;
      // Edge detect on the synchronized level
      prev_q  <= sync2_q;
      pulse_q <= sync2_q ^ prev_q;
    end
  end

  assign valid_o = pulse_q;
  assign ack_o   = sync2_q;

endmodule

//--- hdl/l2_bank.sv
// One 32-bit L2 bank
// Single-port memory with registered read data
module l2_bank #(
  parameter int unsigned Words = 256
) (
  input  logic                       clk_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [$clog2(Words)-1:0]   addr_i,
  input  host_pkg::bank_data_t       wdata_i,
  output host_pkg::bank_data_t       rdata_o
);

  host_pkg::bank_data_t mem_q [Words];
  host_pkg::bank_data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end
      // Read-before-write on a write access
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hdl/l2_subsystem.sv
// Interleaved L2 scratchpad
// A 64-bit row is stored across a pair of 32-bit banks, low half in the
// even bank and high half in the odd bank, pairs interleaved on row index
module l2_subsystem #(
  parameter int unsigned NbBanks   = host_pkg::NB_L2_BANKS,
  parameter int unsigned BankWords = host_pkg::L2_BANK_WORDS,
  localparam int unsigned NbPairs       = NbBanks / 2,
  localparam int unsigned RowWidth      = $clog2(NbPairs * BankWords),
  localparam int unsigned BankAddrWidth = $clog2(BankWords),
  localparam int unsigned SelWidth      = (NbPairs > 1) ? $clog2(NbPairs) : 1
) (
  input  logic                clk_i,
  input  logic                req_i,
  input  logic                we_i,
  input  logic [RowWidth-1:0] row_i,
  input  host_pkg::data_t     wdata_i,
  output host_pkg::data_t     rdata_o
);

  logic [SelWidth-1:0]      pair_sel;
  logic [SelWidth-1:0]      pair_q;
  logic [BankAddrWidth-1:0] bank_row;
  host_pkg::bank_data_t     bank_rdata [NbBanks];

  // Low part of the row index picks the pair, the rest the bank row
  assign pair_sel = SelWidth'(row_i % NbPairs);
  assign bank_row = BankAddrWidth'(row_i / NbPairs);

  for (genvar b = 0; b < NbBanks; b++) begin : gen_bank
    logic bank_req;

    assign bank_req = req_i && (pair_sel == SelWidth'(b / 2));

    l2_bank #(
      .Words ( BankWords )
    ) i_l2_bank (
      .clk_i   ( clk_i                                  ),
      .req_i   ( bank_req                               ),
      .we_i    ( we_i                                   ),
      .addr_i  ( bank_row                               ),
      .wdata_i ( wdata_i[32*(b%2) +: 32]                ),
      .rdata_o ( bank_rdata[b]                          )
    );
  end

  // Remember which pair answers next cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      pair_q <= pair_sel;
    end
  end

  assign rdata_o = {bank_rdata[2*pair_q+1], bank_rdata[2*pair_q]};

endmodule

//--- hdl/soc_ctrl_regs.sv
// Cluster control registers
// Fetch enable, self-boot enable and host-to-cluster interrupt bits,
// DMA and EOC event counters with clear on write, and a scratch word
module soc_ctrl_regs (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            req_i,
  input  logic            we_i,
  input  logic [4:0]      offset_i,
  input  host_pkg::data_t wdata_i,
  output host_pkg::data_t rdata_o,
  input  logic            dma_evt_i,
  input  logic            cluster_eoc_i,
  output logic            cluster_fetch_en_o,
  output logic            cluster_en_sa_boot_o,
  output logic            h2c_irq_o
);

  logic [2:0]      ctrl_q;
  host_pkg::data_t dma_cnt_q;
  host_pkg::data_t eoc_cnt_q;
  host_pkg::data_t scratch_q;
  host_pkg::data_t rdata_q;
  host_pkg::data_t rd_mux;
  logic            eoc_prev_q;
  logic            eoc_rise;
  logic            wr_en;

  assign wr_en    = req_i & we_i;
  assign eoc_rise = cluster_eoc_i & ~eoc_prev_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q     <= '0;
      dma_cnt_q  <= '0;
      eoc_cnt_q  <= '0;
      scratch_q  <= '0;
      eoc_prev_q <= 1'b0;
    end else begin
      eoc_prev_q <= cluster_eoc_i;

      if (wr_en && offset_i == host_pkg::REG_CTRL) begin
        ctrl_q <= wdata_i[2:0];
      end

      if (wr_en && offset_i == host_pkg::REG_SCRATCH) begin
        scratch_q <= wdata_i;
      end

      // Clear beats a same-cycle event
      if (wr_en && offset_i == host_pkg::REG_DMA_CNT) begin
        dma_cnt_q <= '0;
      end else if (dma_evt_i) begin
        dma_cnt_q <= dma_cnt_q + 1'b1;
      end

      if (wr_en && offset_i == host_pkg::REG_EOC_CNT) begin
        eoc_cnt_q <= '0;
      end else if (eoc_rise) begin
        eoc_cnt_q <= eoc_cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (offset_i)
      host_pkg::REG_CTRL:    rd_mux = host_pkg::data_t'(ctrl_q);
      host_pkg::REG_DMA_CNT: rd_mux = dma_cnt_q;
      host_pkg::REG_EOC_CNT: rd_mux = eoc_cnt_q;
      host_pkg::REG_SCRATCH: rd_mux = scratch_q;
      default:               rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= rd_mux;
    end
  end

  assign rdata_o              = rdata_q;
  assign cluster_fetch_en_o   = ctrl_q[host_pkg::CTRL_FETCH_EN_BIT];
  assign cluster_en_sa_boot_o = ctrl_q[host_pkg::CTRL_SA_BOOT_BIT];
  assign h2c_irq_o            = ctrl_q[host_pkg::CTRL_H2C_IRQ_BIT];

endmodule

//--- hdl/host_xbar.sv
// Host request router
// Decodes each request to the L2 or the control registers, flags bad
// addresses, and returns the response of the registered target one cycle on
module host_xbar #(
  parameter int unsigned NbL2Banks   = host_pkg::NB_L2_BANKS,
  parameter int unsigned L2BankWords = host_pkg::L2_BANK_WORDS,
  localparam int unsigned RowWidth   = $clog2((NbL2Banks / 2) * L2BankWords)
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                req_valid_i,
  input  logic                req_we_i,
  input  host_pkg::addr_t     req_addr_i,
  input  host_pkg::data_t     req_wdata_i,
  output logic                rsp_valid_o,
  output host_pkg::data_t     rsp_rdata_o,
  output logic                rsp_err_o,
  output logic                l2_req_o,
  output logic                l2_we_o,
  output logic [RowWidth-1:0] l2_row_o,
  output host_pkg::data_t     l2_wdata_o,
  input  host_pkg::data_t     l2_rdata_i,
  output logic                ctrl_req_o,
  output logic [4:0]          ctrl_offset_o,
  input  host_pkg::data_t     ctrl_rdata_i
);

  localparam host_pkg::addr_t L2Size = host_pkg::addr_t'(NbL2Banks * L2BankWords * 4);

  host_pkg::addr_t   l2_off;
  host_pkg::addr_t   ctrl_off;
  logic              req_ok;
  logic              ctrl_off_ok;
  host_pkg::target_e tgt;
  host_pkg::target_e tgt_q;
  logic              valid_q;
  logic              we_q;

  // Requests while the SoC is in reset are dropped
  assign req_ok   = req_valid_i & ~reset_i;
  assign l2_off   = req_addr_i - host_pkg::L2_BASE;
  assign ctrl_off = req_addr_i - host_pkg::CTRL_BASE;

  always_comb begin
    case (ctrl_off[4:0])
      host_pkg::REG_CTRL,
      host_pkg::REG_DMA_CNT,
      host_pkg::REG_EOC_CNT,
      host_pkg::REG_SCRATCH: ctrl_off_ok = 1'b1;
      default:               ctrl_off_ok = 1'b0;
    endcase
  end

  // Offsets below the base wrap to large values and fail the size check
  always_comb begin
    if (req_addr_i[2:0] != 3'b000) begin
      tgt = host_pkg::TGT_ERR;
    end else if (l2_off < L2Size) begin
      tgt = host_pkg::TGT_L2;
    end else if (ctrl_off < host_pkg::CTRL_SIZE && ctrl_off_ok) begin
      tgt = host_pkg::TGT_CTRL;
    end else begin
      tgt = host_pkg::TGT_ERR;
    end
  end

  assign l2_req_o      = req_ok && (tgt == host_pkg::TGT_L2);
  assign l2_we_o       = req_we_i;
  assign l2_row_o      = l2_off[RowWidth+2:3];
  assign l2_wdata_o    = req_wdata_i;
  assign ctrl_req_o    = req_ok && (tgt == host_pkg::TGT_CTRL);
  assign ctrl_offset_o = ctrl_off[4:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      tgt_q   <= host_pkg::TGT_ERR;
      we_q    <= 1'b0;
    end else begin
      valid_q <= req_ok;
      tgt_q   <= tgt;
      we_q    <= req_we_i;
    end
  end

  // Response side
  always_comb begin
    rsp_rdata_o = '0;
    if (valid_q && !we_q) begin
      case (tgt_q)
        host_pkg::TGT_L2:   rsp_rdata_o = l2_rdata_i;
        host_pkg::TGT_CTRL: rsp_rdata_o = ctrl_rdata_i;
        default:            rsp_rdata_o = '0;
      endcase
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_err_o   = valid_q && (tgt_q == host_pkg::TGT_ERR);

endmodule

//--- hdl/host_domain.sv
// Host domain top
// Host port routed to an interleaved L2 and the cluster control registers,
// cluster DMA event crossing and SoC/cluster reset sequencing
module host_domain #(
  parameter int unsigned NbL2Banks   = host_pkg::NB_L2_BANKS,
  parameter int unsigned L2BankWords = host_pkg::L2_BANK_WORDS
) (
  input  logic            clk_i,
  input  logic            reset_i,
  // Host request and response
  input  logic            req_valid_i,
  input  logic            req_we_i,
  input  host_pkg::addr_t req_addr_i,
  input  host_pkg::data_t req_wdata_i,
  output logic            rsp_valid_o,
  output host_pkg::data_t rsp_rdata_o,
  output logic            rsp_err_o,
  // Cluster side
  input  logic            dma_pe_evt_valid_i,
  input  logic            cluster_eoc_i,
  output logic            dma_pe_evt_ack_o,
  output logic            cluster_fetch_en_o,
  output logic            cluster_en_sa_boot_o,
  output logic            h2c_irq_o,
  output logic            soc_rst_o,
  output logic            cluster_rst_o
);

  localparam int unsigned L2RowWidth = $clog2((NbL2Banks / 2) * L2BankWords);

  logic                  dma_evt;
  logic                  l2_req;
  logic                  l2_we;
  logic [L2RowWidth-1:0] l2_row;
  host_pkg::data_t       l2_wdata;
  host_pkg::data_t       l2_rdata;
  logic                  ctrl_req;
  logic [4:0]            ctrl_offset;
  host_pkg::data_t       ctrl_rdata;

  reset_sync i_reset_sync (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .soc_rst_o     ( soc_rst_o     ),
    .cluster_rst_o ( cluster_rst_o )
  );

  // DMA events come from the cluster side
  edge_propagator_rx i_dma_evt_rx (
    .clk_i   ( clk_i              ),
    .reset_i ( cluster_rst_o      ),
    .valid_i ( dma_pe_evt_valid_i ),
    .valid_o ( dma_evt            ),
    .ack_o   ( dma_pe_evt_ack_o   )
  );

  host_xbar #(
    .NbL2Banks   ( NbL2Banks   ),
    .L2BankWords ( L2BankWords )
  ) i_host_xbar (
    .clk_i         ( clk_i       ),
    .reset_i       ( soc_rst_o   ),
    .req_valid_i   ( req_valid_i ),
    .req_we_i      ( req_we_i    ),
    .req_addr_i    ( req_addr_i  ),
    .req_wdata_i   ( req_wdata_i ),
    .rsp_valid_o   ( rsp_valid_o ),
    .rsp_rdata_o   ( rsp_rdata_o ),
    .rsp_err_o     ( rsp_err_o   ),
    .l2_req_o      ( l2_req      ),
    .l2_we_o       ( l2_we       ),
    .l2_row_o      ( l2_row      ),
    .l2_wdata_o    ( l2_wdata    ),
    .l2_rdata_i    ( l2_rdata    ),
    .ctrl_req_o    ( ctrl_req    ),
    .ctrl_offset_o ( ctrl_offset ),
    .ctrl_rdata_i  ( ctrl_rdata  )
  );

  l2_subsystem #(
    .NbBanks   ( NbL2Banks   ),
    .BankWords ( L2BankWords )
  ) i_l2_subsystem (
    .clk_i   ( clk_i    ),
    .req_i   ( l2_req   ),
    .we_i    ( l2_we    ),
    .row_i   ( l2_row   ),
    .wdata_i ( l2_wdata ),
    .rdata_o ( l2_rdata )
  );

  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i                ( clk_i                ),
    .reset_i              ( soc_rst_o            ),
    .req_i                ( ctrl_req             ),
    .we_i                 ( req_we_i             ),
    .offset_i             ( ctrl_offset          ),
    .wdata_i              ( req_wdata_i          ),
    .rdata_o              ( ctrl_rdata           ),
    .dma_evt_i            ( dma_evt              ),
    .cluster_eoc_i        ( cluster_eoc_i        ),
    .cluster_fetch_en_o   ( cluster_fetch_en_o   ),
    .cluster_en_sa_boot_o ( cluster_en_sa_boot_o ),
    .h2c_irq_o            ( h2c_irq_o            )
  );

endmodule

//--- bench/host_domain_assertions.sv
// Protocol checks bound to the host domain top
// Response timing, error flag qualification and control outputs in reset
module host_domain_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic soc_rst_o,
  input logic req_valid_i,
  input logic rsp_valid_o,
  input logic rsp_err_o,
  input logic cluster_fetch_en_o,
  input logic cluster_en_sa_boot_o,
  input logic h2c_irq_o
);

  int unsigned fail_count = 0;

  // A request taken outside reset is answered in the next cycle
  rsp_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i && !soc_rst_o |=> rsp_valid_o)
    else begin
      fail_count++;
      $error("rsp_valid_o missing one cycle after a request");
    end

  // No response without a request one cycle earlier
  rsp_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o |-> $past(req_valid_i && !soc_rst_o))
    else begin
      fail_count++;
      $error("rsp_valid_o high without a request in the previous cycle");
    end

  err_in_rsp: assert property (@(posedge clk_i) rsp_err_o |-> rsp_valid_o)
    else begin
      fail_count++;
      $error("rsp_err_o high outside a response cycle");
    end

  // Control bits clear on the first edge that sees soc_rst_o high
  ctrl_low_in_reset: assert property (@(posedge clk_i)
    soc_rst_o && $past(soc_rst_o) |->
      !(cluster_fetch_en_o || cluster_en_sa_boot_o || h2c_irq_o))
    else begin
      fail_count++;
      $error("cluster control output high while the SoC is in reset");
    end

endmodule

bind host_domain host_domain_assertions i_assertions (
  .clk_i                ( clk_i                ),
  .reset_i              ( reset_i              ),
  .soc_rst_o            ( soc_rst_o            ),
  .req_valid_i          ( req_valid_i          ),
  .rsp_valid_o          ( rsp_valid_o          ),
  .rsp_err_o            ( rsp_err_o            ),
  .cluster_fetch_en_o   ( cluster_fetch_en_o   ),
  .cluster_en_sa_boot_o ( cluster_en_sa_boot_o ),
  .h2c_irq_o            ( h2c_irq_o            )
);

//--- bench/tb_host_domain.sv
// Testbench for the host domain top
// Random L2 and register traffic checked against a reference model,
// cluster event counting, reset sequencing and error responses
module tb_host_domain;

  localparam int unsigned NB_BANKS     = host_pkg::NB_L2_BANKS;
  localparam int unsigned BANK_WORDS   = host_pkg::L2_BANK_WORDS;
  localparam int unsigned L2_ROWS      = NB_BANKS * BANK_WORDS / 2;
  localparam int unsigned L2_SIZE      = L2_ROWS * 8;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned NUM_L2_OPS   = 400;
  localparam int unsigned NUM_CTRL_OPS = 20;
  localparam int unsigned MAX_EVENTS   = 16;
  localparam int unsigned NUM_ERR_OPS  = 40;
  localparam int unsigned NUM_READBACK = 16;
  // Rough cycle count of all phases
  localparam int unsigned PLANNED_CYCLES = RESET_CYCLES + 8 + NUM_L2_OPS + 4 * NUM_CTRL_OPS
                                         + 9 * MAX_EVENTS + 12 + NUM_ERR_OPS + 8
                                         + NUM_READBACK + 16;
  localparam int unsigned TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;

  logic            clk;
  logic            reset;
  logic            req_valid;
  logic            req_we;
  host_pkg::addr_t req_addr;
  host_pkg::data_t req_wdata;
  logic            rsp_valid;
  host_pkg::data_t rsp_rdata;
  logic            rsp_err;
  logic            dma_toggle;
  logic            cluster_eoc;
  logic            dma_ack;
  logic            fetch_en;
  logic            sa_boot;
  logic            h2c_irq;
  logic            soc_rst;
  logic            cluster_rst;

  // Reference model
  host_pkg::data_t l2_model [int unsigned];
  int unsigned     written_rows [$];
  logic [2:0]      ctrl_model;
  host_pkg::data_t dma_cnt_model;
  host_pkg::data_t eoc_cnt_model;
  host_pkg::data_t scratch_model;

  // Expected response of the request in flight
  logic            pend_valid;
  logic            pend_err;
  host_pkg::data_t pend_rdata;
  string           pend_what;

  integer          seed;
  int unsigned     cycle_count = 0;

  host_domain #(
    .NbL2Banks   ( NB_BANKS   ),
    .L2BankWords ( BANK_WORDS )
  ) dut (
    .clk_i                ( clk         ),
    .reset_i              ( reset       ),
    .req_valid_i          ( req_valid   ),
    .req_we_i             ( req_we      ),
    .req_addr_i           ( req_addr    ),
    .req_wdata_i          ( req_wdata   ),
    .rsp_valid_o          ( rsp_valid   ),
    .rsp_rdata_o          ( rsp_rdata   ),
    .rsp_err_o            ( rsp_err     ),
    .dma_pe_evt_valid_i   ( dma_toggle  ),
    .cluster_eoc_i        ( cluster_eoc ),
    .dma_pe_evt_ack_o     ( dma_ack     ),
    .cluster_fetch_en_o   ( fetch_en    ),
    .cluster_en_sa_boot_o ( sa_boot     ),
    .h2c_irq_o            ( h2c_irq     ),
    .soc_rst_o            ( soc_rst     ),
    .cluster_rst_o        ( cluster_rst )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic stop_on_failure();
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_failure();
    end
  end

  task automatic check_rdata(input host_pkg::data_t actual, input host_pkg::data_t expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s returned %h, expected %h", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_err(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s error flag %b, expected %b", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_ctrl_outputs(input logic [2:0] actual, input logic [2:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: cluster control outputs %b, expected %b", $time, actual,
               expected);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  // Checks the previous response and drives the next request
  task automatic step_req(input logic valid, input logic we, input host_pkg::addr_t addr,
                          input host_pkg::data_t wdata, input host_pkg::data_t exp_rdata,
                          input logic exp_err, input string what);
    @(negedge clk);
    check_bit(rsp_valid, pend_valid, "rsp_valid_o");
    if (pend_valid) begin
      check_err(rsp_err, pend_err, pend_what);
      check_rdata(rsp_rdata, pend_rdata, pend_what);
    end
    // Fetch enable in bit 0 up to the interrupt in bit 2
    check_ctrl_outputs({h2c_irq, sa_boot, fetch_en}, ctrl_model);
    req_valid  = valid;
    req_we     = we;
    req_addr   = addr;
    req_wdata  = wdata;
    pend_valid = valid;
    pend_err   = exp_err;
    pend_rdata = exp_rdata;
    pend_what  = what;
  endtask

  task automatic idle(input int unsigned cycles);
    repeat (cycles) step_req(1'b0, 1'b0, '0, '0, '0, 1'b0, "idle");
  endtask

  task automatic l2_write(input int unsigned row, input host_pkg::data_t data);
    step_req(1'b1, 1'b1, host_pkg::L2_BASE + row * 8, data, '0, 1'b0, "L2 write");
    l2_model[row] = data;
    written_rows.push_back(row);
  endtask

  task automatic l2_read(input int unsigned row);
    step_req(1'b1, 1'b0, host_pkg::L2_BASE + row * 8, '0, l2_model[row], 1'b0,
             $sformatf("L2 read of row %0d", row));
  endtask

  task automatic reg_write(input logic [4:0] offset, input host_pkg::data_t data);
    step_req(1'b1, 1'b1, host_pkg::CTRL_BASE + offset, data, '0, 1'b0, "register write");
    case (offset)
      host_pkg::REG_CTRL:    ctrl_model = data[2:0];
      host_pkg::REG_DMA_CNT: dma_cnt_model = '0;
      host_pkg::REG_EOC_CNT: eoc_cnt_model = '0;
      default:               scratch_model = data;
    endcase
  endtask

  task automatic reg_read(input logic [4:0] offset);
    host_pkg::data_t expected;
    case (offset)
      host_pkg::REG_CTRL:    expected = host_pkg::data_t'(ctrl_model);
      host_pkg::REG_DMA_CNT: expected = dma_cnt_model;
      host_pkg::REG_EOC_CNT: expected = eoc_cnt_model;
      default:               expected = scratch_model;
    endcase
    step_req(1'b1, 1'b0, host_pkg::CTRL_BASE + offset, '0, expected, 1'b0,
             $sformatf("register read at offset %h", offset));
  endtask

  // Write then read an address that must be rejected
  task automatic bad_access(input host_pkg::addr_t addr, input host_pkg::data_t data);
    step_req(1'b1, 1'b1, addr, data, '0, 1'b1, $sformatf("write to %h", addr));
    step_req(1'b1, 1'b0, addr, '0, '0, 1'b1, $sformatf("read from %h", addr));
  endtask

  function automatic logic outside_windows(input host_pkg::addr_t addr);
    return (addr < host_pkg::L2_BASE || addr >= host_pkg::L2_BASE + L2_SIZE) &&
           (addr < host_pkg::CTRL_BASE || addr >= host_pkg::CTRL_BASE + host_pkg::CTRL_SIZE);
  endfunction

  initial begin
    logic [31:0]     r;
    logic [2:0]      low;
    int unsigned     n_events;
    host_pkg::addr_t addr;

    seed          = 32'h3b6c_66cc;
    reset         = 1'b1;
    dma_toggle    = 1'b0;
    cluster_eoc   = 1'b0;
    // A register write held during reset must be ignored
    req_valid     = 1'b1;
    req_we        = 1'b1;
    req_addr      = host_pkg::CTRL_BASE;
    req_wdata     = '1;
    pend_valid    = 1'b0;
    pend_err      = 1'b0;
    pend_rdata    = '0;
    pend_what     = "";
    ctrl_model    = '0;
    dma_cnt_model = '0;
    eoc_cnt_model = '0;
    scratch_model = '0;

    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_bit(soc_rst, 1'b1, "soc_rst_o one cycle after reset release");
    @(negedge clk);
    check_bit(soc_rst, 1'b0, "soc_rst_o two cycles after reset release");
    check_bit(cluster_rst, 1'b1, "cluster_rst_o as the SoC leaves reset");
    req_valid = 1'b0;
    @(negedge clk);
    check_bit(cluster_rst, 1'b0, "cluster_rst_o one cycle after soc_rst_o");
    check_bit(rsp_valid, 1'b0, "rsp_valid_o for a request made in reset");
    check_bit(dma_ack, 1'b0, "dma_pe_evt_ack_o after reset");
    reg_read(host_pkg::REG_CTRL);
    reg_read(host_pkg::REG_DMA_CNT);
    reg_read(host_pkg::REG_EOC_CNT);
    reg_read(host_pkg::REG_SCRATCH);

    // Back to back L2 traffic that reads only rows already written
    for (int i = 0; i < NUM_L2_OPS; i++) begin
      r = $random(seed);
      if (written_rows.size() == 0 || r[0]) begin
        l2_write(r[31:1] % L2_ROWS, {$random(seed), $random(seed)});
      end else begin
        l2_read(written_rows[r[31:1] % written_rows.size()]);
      end
    end

    for (int i = 0; i < NUM_CTRL_OPS; i++) begin
      reg_write(host_pkg::REG_CTRL, {$random(seed), $random(seed)});
      reg_read(host_pkg::REG_CTRL);
      reg_write(host_pkg::REG_SCRATCH, {$random(seed), $random(seed)});
      reg_read(host_pkg::REG_SCRATCH);
    end

    // Each cluster event gets time to cross before the next
    r = $random(seed);
    n_events = 4 + r[3:0] % (MAX_EVENTS - 3);
    for (int i = 0; i < n_events; i++) begin
      r = $random(seed);
      // First a DMA toggle, then an EOC pulse, then random kinds
      if (i == 0 || (i != 1 && r[0])) begin
        dma_toggle = ~dma_toggle;
        dma_cnt_model = dma_cnt_model + 1;
      end else begin
        cluster_eoc = 1'b1;
        idle(1);
        cluster_eoc = 1'b0;
        eoc_cnt_model = eoc_cnt_model + 1;
      end
      idle(6);
    end
    check_bit(dma_ack, dma_toggle, "dma_pe_evt_ack_o after the last toggle");
    reg_read(host_pkg::REG_DMA_CNT);
    reg_read(host_pkg::REG_EOC_CNT);
    reg_write(host_pkg::REG_DMA_CNT, {$random(seed), $random(seed)});
    reg_write(host_pkg::REG_EOC_CNT, {$random(seed), $random(seed)});
    reg_read(host_pkg::REG_DMA_CNT);
    reg_read(host_pkg::REG_EOC_CNT);

    // Unaligned accesses and accesses outside both windows or past a window end
    bad_access(host_pkg::L2_BASE + L2_SIZE, {$random(seed), $random(seed)});
    bad_access(host_pkg::L2_BASE - 8, {$random(seed), $random(seed)});
    bad_access(host_pkg::CTRL_BASE + host_pkg::CTRL_SIZE, {$random(seed), $random(seed)});
    bad_access(host_pkg::CTRL_BASE - 8, {$random(seed), $random(seed)});
    for (int i = 0; i < NUM_ERR_OPS / 2; i++) begin
      r = $random(seed);
      low = (r[4:2] == 3'd0) ? 3'd5 : r[4:2];
      case (r[1:0])
        2'd0: addr = host_pkg::L2_BASE + (r[31:8] % L2_ROWS) * 8 + low;
        2'd1: addr = host_pkg::CTRL_BASE + (r[31:8] % 4) * 8 + low;
        2'd2: addr = {r[31:3], 3'b000};
        default: addr = host_pkg::L2_BASE + L2_SIZE + {r[9:5], 3'b000};
      endcase
      if (r[1:0] == 2'd2 && !outside_windows(addr)) begin
        addr = host_pkg::CTRL_BASE + host_pkg::CTRL_SIZE;
      end
      bad_access(addr, {$random(seed), $random(seed)});
    end

    // Nothing may have changed
    reg_read(host_pkg::REG_CTRL);
    reg_read(host_pkg::REG_DMA_CNT);
    reg_read(host_pkg::REG_EOC_CNT);
    reg_read(host_pkg::REG_SCRATCH);
    for (int i = 0; i < NUM_READBACK; i++) begin
      r = $random(seed);
      l2_read(written_rows[r % written_rows.size()]);
    end
    idle(2);

    if (dut.i_assertions.fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures were reported", dut.i_assertions.fail_count);
      stop_on_failure();
    end
  end

endmodule

//--- sim.f
hdl/host_pkg.sv
hdl/reset_sync.sv
hdl/edge_propagator_rx.sv
hdl/l2_bank.sv
hdl/l2_subsystem.sv
hdl/soc_ctrl_regs.sv
hdl/host_xbar.sv
hdl/host_domain.sv
bench/host_domain_assertions.sv
bench/tb_host_domain.sv

//--- Bender.yml
package:
  name: host_domain

sources:
  # RTL in compile order, package first
  - files:
      - hdl/host_pkg.sv
      - hdl/reset_sync.sv
      - hdl/edge_propagator_rx.sv
      - hdl/l2_bank.sv
      - hdl/l2_subsystem.sv
      - hdl/soc_ctrl_regs.sv
      - hdl/host_xbar.sv
      - hdl/host_domain.sv

  - target: simulation
    files:
      - bench/host_domain_assertions.sv
      - bench/tb_host_domain.sv
